// ==== Makefile ====
# Verilator build and run of the multiply/divide testbench
# run from the project root, the testbench reads dv/imuldiv_input.dat from here

VERILATOR ?= verilator
TOP       ?= tb_imuldiv
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter-out +incdir+%,$(shell cat $(FLIST)))
HDRS := $(wildcard design/*.svh)
DATA := dv/imuldiv_input.dat
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass or fail is taken from the log
run: $(BIN) $(DATA)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/imuldiv_ctrl_pkg.sv ====
// control types shared by the iterative multiplier and divider
`default_nettype none

`include "imuldiv_defines.svh"

package imuldiv_ctrl_pkg;

  // iteration FSM
  // idle takes a request, calc runs the loop, done holds the response
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } iter_state_e;

  // down-counter for the 32 loop steps
  typedef logic [`IMULDIV_ITER_W-1:0] iter_count_t;

endpackage

`default_nettype wire

// ==== design/imuldiv_defines.svh ====
// width macros shared by the RTL and the testbench
// the packed response format ties these together, so change them as a set
`ifndef IMULDIV_DEFINES_SVH
`define IMULDIV_DEFINES_SVH

// operand width of the host processor
`define IMULDIV_XLEN 32

// one response word
// a divide packs the remainder above the quotient
`define IMULDIV_RESULT_W (2 * `IMULDIV_XLEN)

// iteration counter width
// loaded with XLEN-1 and counted down to zero, one step per cycle
`define IMULDIV_ITER_W 5

`endif

// ==== design/imuldiv_msg_pkg.sv ====
// request and response message types of the multiply/divide unit
// opcode 2'b11 is not a valid function and produces no response
`default_nettype none

`include "imuldiv_defines.svh"

package imuldiv_msg_pkg;

  // ----------------------------------------------------------------------
  // request opcode
  // ----------------------------------------------------------------------

  typedef enum logic [1:0] {
    // signed 32x32 -> 64 product
    fn_mul  = 2'd0,
    // signed divide, remainder takes dividend sign
    fn_div  = 2'd1,
    // unsigned divide
    fn_divu = 2'd2
  } fn_e;

  // ----------------------------------------------------------------------
  // payload
  // ----------------------------------------------------------------------

  typedef logic [`IMULDIV_XLEN-1:0] operand_t;

  // {remainder, quotient} for divides, full product for multiplies
  typedef logic [`IMULDIV_RESULT_W-1:0] result_t;

endpackage

`default_nettype wire

// ==== design/imuldiv_top.sv ====
// multiply/divide unit top, one operation in flight at a time
// adds no cycles, latency is that of the selected unit
`timescale 1ns/1ps
`default_nettype none

module imuldiv_top (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        req_val,
  output logic                       req_rdy,
  input  wire imuldiv_msg_pkg::fn_e  req_fn,
  input  wire imuldiv_msg_pkg::operand_t req_a,
  input  wire imuldiv_msg_pkg::operand_t req_b,
  output logic                       resp_val,
  input  wire                        resp_rdy,
  output imuldiv_msg_pkg::result_t   resp_result
);

  import imuldiv_msg_pkg::*;

  logic    mul_req_val;
  logic    mul_req_rdy;
  logic    mul_resp_val;
  result_t mul_resp_result;

  logic    div_req_val;
  logic    div_req_rdy;
  logic    div_resp_val;
  result_t div_resp_result;

  // ----------------------------------------------------------------------
  // request steering
  // ----------------------------------------------------------------------

  // both units idle before anything is taken
  assign req_rdy = mul_req_rdy && div_req_rdy;

  // unit valids also wait for req_rdy, so an idle unit never grabs
  // a request while the other one is still busy
  assign mul_req_val = req_val && req_rdy && (req_fn == fn_mul);
  assign div_req_val = req_val && req_rdy && ((req_fn == fn_div) || (req_fn == fn_divu));

  int_mul_iterative mul (
    .clk         (clk),
    .reset       (reset),
    .req_val     (mul_req_val),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_rdy     (mul_req_rdy),
    .resp_val    (mul_resp_val),
    .resp_result (mul_resp_result),
    .resp_rdy    (resp_rdy)
  );

  int_div_iterative div (
    .clk         (clk),
    .reset       (reset),
    .req_val     (div_req_val),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_rdy     (div_req_rdy),
    .resp_val    (div_resp_val),
    .resp_result (div_resp_result),
    .resp_rdy    (resp_rdy)
  );

  // ----------------------------------------------------------------------
  // response merge
  // ----------------------------------------------------------------------

  assign resp_val    = mul_resp_val || div_resp_val;
  assign resp_result = mul_resp_val ? mul_resp_result : div_resp_result;

  // single operation in flight, so never two responses at once
  a_one_resp : assert property (
    @(posedge clk) disable iff (reset) !(mul_resp_val && div_resp_val)
  );

endmodule

`default_nettype wire

// ==== design/int_div_iterative.sv ====
// iterative restoring divider for fn_div and fn_divu, same 33-cycle schedule as the multiplier
// response is {remainder, quotient}; a zero divisor gives all-ones quotient, remainder = dividend
`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_defines.svh"

module int_div_iterative (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        req_val,
  input  wire imuldiv_msg_pkg::fn_e  req_fn,
  input  wire imuldiv_msg_pkg::operand_t req_a,
  input  wire imuldiv_msg_pkg::operand_t req_b,
  output logic                       req_rdy,
  output logic                       resp_val,
  output imuldiv_msg_pkg::result_t   resp_result,
  input  wire                        resp_rdy
);

  import imuldiv_msg_pkg::*;
  import imuldiv_ctrl_pkg::*;

  iter_state_e state;
  iter_count_t cntr;

  // remainder in the upper half, dividend/quotient bits in the lower half
  result_t  rq_reg;
  operand_t divisor_reg;
  logic     quot_neg;
  logic     rem_neg;
  logic     div_zero;

  logic     is_signed;
  operand_t a_mag;
  operand_t b_mag;
  // one extra bit for the partial remainder after the shift
  logic [`IMULDIV_XLEN:0] rem_shift;
  logic [`IMULDIV_XLEN:0] rem_diff;
  result_t  rq_next;
  operand_t quot_mag;
  operand_t rem_mag;
  operand_t quot_out;
  operand_t rem_out;
  logic     req_go;
  logic     resp_go;

  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);
  assign req_go   = req_val && req_rdy;
  assign resp_go  = resp_val && resp_rdy;

  // ----------------------------------------------------------------------
  // operand conditioning
  // ----------------------------------------------------------------------

  // fn_divu keeps raw operands
  assign is_signed = (req_fn == fn_div);
  assign a_mag = (is_signed && req_a[`IMULDIV_XLEN-1]) ? -req_a : req_a;
  assign b_mag = (is_signed && req_b[`IMULDIV_XLEN-1]) ? -req_b : req_b;

  // ----------------------------------------------------------------------
  // one restoring step
  // ----------------------------------------------------------------------

  // shift left by one and trial-subtract the divisor from the top half
  assign rem_shift = rq_reg[`IMULDIV_RESULT_W-1:`IMULDIV_XLEN-1];
  assign rem_diff  = rem_shift - {1'b0, divisor_reg};

  // borrow means restore, quotient bit 0
  assign rq_next = rem_diff[`IMULDIV_XLEN]
    ? {rq_reg[`IMULDIV_RESULT_W-2:0], 1'b0}
    : {rem_diff[`IMULDIV_XLEN-1:0], rq_reg[`IMULDIV_XLEN-2:0], 1'b1};

  // ----------------------------------------------------------------------
  // FSM and counter
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      cntr  <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state <= st_calc;
            cntr  <= iter_count_t'(`IMULDIV_XLEN - 1);
          end
        end
        st_calc: begin
          if (cntr == '0) begin
            state <= st_done;
          end else begin
            cntr <= cntr - iter_count_t'(1);
          end
        end
        st_done: if (resp_go) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // payload and flags, captured on the request handshake
  always_ff @(posedge clk) begin
    if (req_go) begin
      rq_reg      <= result_t'(a_mag);
      divisor_reg <= b_mag;
      quot_neg    <= is_signed && (req_a[`IMULDIV_XLEN-1] ^ req_b[`IMULDIV_XLEN-1]);
      // remainder follows the dividend
      rem_neg     <= is_signed && req_a[`IMULDIV_XLEN-1];
      div_zero    <= (req_b == '0);
    end else if (state == st_calc) begin
      rq_reg <= rq_next;
    end
  end

  // ----------------------------------------------------------------------
  // sign correction and packing
  // ----------------------------------------------------------------------

  assign quot_mag = rq_reg[`IMULDIV_XLEN-1:0];
  assign rem_mag  = rq_reg[`IMULDIV_RESULT_W-1:`IMULDIV_XLEN];

  // the loop already leaves |dividend| as remainder for a zero divisor
  assign quot_out = div_zero ? '1 : (quot_neg ? -quot_mag : quot_mag);
  assign rem_out  = rem_neg ? -rem_mag : rem_mag;

  assign resp_result = {rem_out, quot_out};

  // response held steady under back-pressure
  a_resp_stable : assert property (
    @(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result))
  );

endmodule

`default_nettype wire

// ==== design/int_mul_dpath.sv ====
// shift-and-add datapath of the iterative multiplier
// works on magnitudes, the sign is applied to the output under control of negate
`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_defines.svh"

module int_mul_dpath (
  input  wire                       clk,
  input  wire                       reset,
  input  wire imuldiv_msg_pkg::operand_t req_a,
  input  wire imuldiv_msg_pkg::operand_t req_b,
  input  wire                       a_en,
  input  wire                       a_sel,
  input  wire                       b_en,
  input  wire                       b_sel,
  input  wire                       result_en,
  input  wire                       add_sel,
  input  wire                       cntr_dec,
  input  wire                       sign_en,
  input  wire                       negate,
  output logic                      count_zero,
  output logic                      b_lsb,
  output logic                      sign,
  output imuldiv_msg_pkg::result_t  resp_result
);

  import imuldiv_msg_pkg::*;
  import imuldiv_ctrl_pkg::*;

  // shifted multiplicand, widened so it can move into the upper half
  result_t     a_reg;
  // multiplier, consumed from the low bit
  operand_t    b_reg;
  // partial product
  result_t     prod_reg;
  iter_count_t cntr;
  logic        sign_reg;

  operand_t    a_mag;
  operand_t    b_mag;
  result_t     prod_next;

  // ----------------------------------------------------------------------
  // operand magnitudes
  // ----------------------------------------------------------------------

  assign a_mag = req_a[`IMULDIV_XLEN-1] ? -req_a : req_a;
  assign b_mag = req_b[`IMULDIV_XLEN-1] ? -req_b : req_b;

  // a_sel low marks the load cycle, product starts from zero there
  // otherwise accumulate the multiplicand when the multiplier bit is set
  assign prod_next = !a_sel ? '0 : (add_sel ? prod_reg + a_reg : prod_reg);

  // ----------------------------------------------------------------------
  // payload registers
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_sel ? (a_reg << 1) : result_t'(a_mag);
    end
    if (b_en) begin
      b_reg <= b_sel ? (b_reg >> 1) : b_mag;
    end
    if (result_en) begin
      prod_reg <= prod_next;
    end
  end

  // counter and sign, loaded together with the operands
  always_ff @(posedge clk) begin
    if (reset) begin
      cntr     <= '0;
      sign_reg <= 1'b0;
    end else if (sign_en) begin
      cntr     <= iter_count_t'(`IMULDIV_XLEN - 1);
      // product negative when exactly one operand is negative
      sign_reg <= req_a[`IMULDIV_XLEN-1] ^ req_b[`IMULDIV_XLEN-1];
    end else if (cntr_dec) begin
      cntr <= cntr - iter_count_t'(1);
    end
  end

  // status back to the FSM
  assign count_zero = (cntr == '0);
  assign b_lsb      = b_reg[0];
  assign sign       = sign_reg;

  assign resp_result = negate ? -prod_reg : prod_reg;

  // FSM must stop decrementing once the last step is reached
  a_cntr_no_underflow : assert property (
    @(posedge clk) disable iff (reset) cntr_dec |-> (cntr != '0)
  );

endmodule

`default_nettype wire

// ==== design/int_mul_iterative.sv ====
// iterative signed multiplier, one request at a time over val/rdy
// fixed 33-cycle latency from request handshake to resp_val
`timescale 1ns/1ps
`default_nettype none

module int_mul_iterative (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        req_val,
  input  wire imuldiv_msg_pkg::operand_t req_a,
  input  wire imuldiv_msg_pkg::operand_t req_b,
  output logic                       req_rdy,
  output logic                       resp_val,
  output imuldiv_msg_pkg::result_t   resp_result,
  input  wire                        resp_rdy
);

  import imuldiv_ctrl_pkg::*;

  iter_state_e state;

  // datapath strobes
  logic a_en;
  logic a_sel;
  logic b_en;
  logic b_sel;
  logic result_en;
  logic add_sel;
  logic cntr_dec;
  logic sign_en;
  logic negate;

  // datapath status
  logic count_zero;
  logic b_lsb;
  logic sign;

  logic req_go;
  logic resp_go;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  int_mul_dpath dpath (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .a_en        (a_en),
    .a_sel       (a_sel),
    .b_en        (b_en),
    .b_sel       (b_sel),
    .result_en   (result_en),
    .add_sel     (add_sel),
    .cntr_dec    (cntr_dec),
    .sign_en     (sign_en),
    .negate      (negate),
    .count_zero  (count_zero),
    .b_lsb       (b_lsb),
    .sign        (sign),
    .resp_result (resp_result)
  );

  // ----------------------------------------------------------------------
  // state register
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: if (req_go) state <= st_calc;
        // last step runs in the cycle that sees count_zero
        st_calc: if (count_zero) state <= st_done;
        st_done: if (resp_go) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // strobes decoded from the state
  // ----------------------------------------------------------------------

  always_comb begin
    req_rdy   = 1'b0;
    resp_val  = 1'b0;
    a_en      = 1'b0;
    a_sel     = 1'b0;
    b_en      = 1'b0;
    b_sel     = 1'b0;
    result_en = 1'b0;
    add_sel   = 1'b0;
    cntr_dec  = 1'b0;
    sign_en   = 1'b0;
    negate    = 1'b0;
    case (state)
      st_idle: begin
        req_rdy = 1'b1;
        // load magnitudes, clear product, set counter and sign
        if (req_val) begin
          a_en      = 1'b1;
          b_en      = 1'b1;
          result_en = 1'b1;
          sign_en   = 1'b1;
        end
      end
      st_calc: begin
        a_en      = 1'b1;
        a_sel     = 1'b1;
        b_en      = 1'b1;
        b_sel     = 1'b1;
        result_en = 1'b1;
        add_sel   = b_lsb;
        cntr_dec  = !count_zero;
      end
      st_done: begin
        resp_val = 1'b1;
        negate   = sign;
      end
      default: begin
      end
    endcase
  end

  // response held steady under back-pressure
  a_resp_stable : assert property (
    @(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result))
  );

  // a request is only taken from idle and starts the loop with the
  // datapath counter loaded
  a_req_in_idle : assert property (
    @(posedge clk) disable iff (reset)
    req_go |-> (state == st_idle) ##1 ((state == st_calc) && !count_zero)
  );

endmodule

`default_nettype wire

// ==== dv/imuldiv_checker.sv ====
// watches the request and response ports of the multiply/divide unit
// expected values come from the last column of the data file, in file order
// relies on one operation in flight, so responses cannot overtake each other
`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_defines.svh"

module imuldiv_checker (
  input  wire                           clk,
  input  wire                           reset,
  input  wire                           req_val,
  input  wire                           req_rdy,
  input  wire                           resp_val,
  input  wire                           resp_rdy,
  input  wire imuldiv_msg_pkg::result_t resp_result,
  output logic                          done,
  output int                            pass_count,
  output int                            fail_count,
  output int                            error_count
);

  import imuldiv_msg_pkg::*;

  // request handshake edge to first edge that samples resp_val high
  localparam int latency = 33;

  fn_e      fn_q[$];
  operand_t a_q[$];
  operand_t b_q[$];
  result_t  exp_q[$];

  int       resp_idx;
  int       cycle_no;
  int       req_cycle;
  logic     started;
  logic     in_flight;
  logic     first_val_seen;
  logic     hold_pending;
  result_t  held_result;

  // ----------------------------------------------------------------------
  // expected values
  // ----------------------------------------------------------------------

  initial begin : read_expected
    int       fd;
    string    line;
    logic [1:0] f;
    operand_t a;
    operand_t b;
    result_t  e;
    fd = $fopen("dv/imuldiv_input.dat", "r");
    if (fd == 0) begin
      $display("checker cannot open dv/imuldiv_input.dat");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) == 0) break;
        // comment and blank lines do not scan
        if ($sscanf(line, "%h %h %h %h", f, a, b, e) == 4) begin
          fn_q.push_back(fn_e'(f));
          a_q.push_back(a);
          b_q.push_back(b);
          exp_q.push_back(e);
        end
      end
      $fclose(fd);
    end
  end

  // one line per response as it is taken
  task automatic check_response();
    if (resp_idx >= exp_q.size()) begin
      error_count = error_count + 1;
      $display("extra response %h after all %0d vectors were answered",
               resp_result, exp_q.size());
    end else if (resp_result === exp_q[resp_idx]) begin
      pass_count = pass_count + 1;
      $display("vector %0d %s a=%h b=%h result=%h ok", resp_idx,
               fn_q[resp_idx].name(), a_q[resp_idx], b_q[resp_idx], resp_result);
    end else begin
      fail_count = fail_count + 1;
      $display("mismatch at %0t: vector %0d resp_result got %h expected %h",
               $time, resp_idx, resp_result, exp_q[resp_idx]);
    end
    resp_idx = resp_idx + 1;
    if (resp_idx == exp_q.size()) done = 1'b1;
  endtask

  // ----------------------------------------------------------------------
  // protocol and timing
  // ----------------------------------------------------------------------

  always @(posedge clk) begin
    if (reset) begin
      done           = 1'b0;
      pass_count     = 0;
      fail_count     = 0;
      error_count    = 0;
      resp_idx       = 0;
      cycle_no       = 0;
      req_cycle      = 0;
      started        = 1'b0;
      in_flight      = 1'b0;
      first_val_seen = 1'b0;
      hold_pending   = 1'b0;
    end else begin
      cycle_no = cycle_no + 1;
      // first edge out of reset, nothing requested yet
      if (!started) begin
        started = 1'b1;
        if (resp_val || !req_rdy) begin
          error_count = error_count + 1;
          $display("after reset resp_val should be low and req_rdy high, saw %b and %b",
                   resp_val, req_rdy);
        end
      end
      // stalled response from the previous edge must still be there, unchanged
      if (hold_pending) begin
        if (!resp_val) begin
          error_count = error_count + 1;
          $display("at %0t resp_val dropped before the response was taken", $time);
        end else if (resp_result !== held_result) begin
          error_count = error_count + 1;
          $display("mismatch at %0t: resp_result under back-pressure got %h expected %h",
                   $time, resp_result, held_result);
        end
      end
      if (in_flight) begin
        if (req_rdy) begin
          error_count = error_count + 1;
          $display("at %0t req_rdy is high while an operation is in flight", $time);
        end
        if (resp_val && !first_val_seen) begin
          first_val_seen = 1'b1;
          if (cycle_no - req_cycle != latency) begin
            error_count = error_count + 1;
            $display("at %0t response came %0d cycles after the request, not %0d",
                     $time, cycle_no - req_cycle, latency);
          end
        end
      end else if (resp_val) begin
        error_count = error_count + 1;
        $display("at %0t resp_val is high with no operation in flight", $time);
      end
      if (resp_val && resp_rdy) begin
        check_response();
        in_flight = 1'b0;
      end
      if (req_val && req_rdy) begin
        in_flight      = 1'b1;
        first_val_seen = 1'b0;
        req_cycle      = cycle_no;
      end
      hold_pending = resp_val && !resp_rdy;
      held_result  = resp_result;
    end
  end

endmodule

`default_nettype wire

// ==== dv/imuldiv_input.dat ====
// columns in hex: fn (0 mul, 1 div, 2 divu), operand a, operand b, expected result
// divide results are remainder (upper 32 bits) above quotient (lower 32 bits)
0 00000007 00000006 000000000000002a
0 fffffff9 00000006 ffffffffffffffd6
0 fffffff9 fffffffa 000000000000002a
0 00000000 80000000 0000000000000000
0 80000000 80000000 4000000000000000
0 7fffffff 7fffffff 3fffffff00000001
0 80000000 7fffffff c000000080000000
0 ffffffff ffffffff 0000000000000001
0 ffffffff 00000002 fffffffffffffffe
0 00012345 fffffff0 ffffffffffedcbb0
1 00000007 00000002 0000000100000003
1 fffffff9 00000002 fffffffffffffffd
1 00000007 fffffffe 00000001fffffffd
1 fffffff9 fffffffe ffffffff00000003
1 80000000 ffffffff 0000000080000000
1 fffffff9 00000000 fffffff9ffffffff
1 00001234 00000000 00001234ffffffff
1 00000000 00000005 0000000000000000
1 00000064 00000007 000000020000000e
2 ffffffff 00000002 000000017fffffff
2 80000000 ffffffff 8000000000000000
2 fffffff9 00000010 000000090fffffff
2 80000000 00000000 80000000ffffffff

// ==== dv/tb_imuldiv.sv ====
// top of the multiply/divide testbench
// vectors come from dv/imuldiv_input.dat, run from the project root
// response back-pressure is random with a fixed seed
`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_defines.svh"

module tb_imuldiv;

  import imuldiv_msg_pkg::*;

  localparam int clk_period   = 40;
  localparam int reset_cycles = 5;
  // 34 cycles per operation, up to 8 more of stall, plus slack
  localparam int cycles_per_vec = 45;

  logic     clk;
  logic     reset;
  logic     req_val;
  logic     req_rdy;
  fn_e      req_fn;
  operand_t req_a;
  operand_t req_b;
  logic     resp_val;
  logic     resp_rdy;
  result_t  resp_result;

  fn_e      vec_fn[$];
  operand_t vec_a[$];
  operand_t vec_b[$];
  int       cycle_limit;
  int       cycle_count;
  int       stall_left;
  int       seed = 32'hd762;

  logic     done;
  int       pass_count;
  int       fail_count;
  int       error_count;

  imuldiv_top uut (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  imuldiv_checker chk (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result),
    .done        (done),
    .pass_count  (pass_count),
    .fail_count  (fail_count),
    .error_count (error_count)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever begin
      #(clk_period / 2) clk = ~clk;
    end
  end

  // ----------------------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------------------

  task automatic load_vectors(input int fd);
    string      line;
    logic [1:0] f;
    operand_t   a;
    operand_t   b;
    result_t    e;
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) == 0) break;
      // expected column is left to the checker
      if ($sscanf(line, "%h %h %h %h", f, a, b, e) == 4) begin
        vec_fn.push_back(fn_e'(f));
        vec_a.push_back(a);
        vec_b.push_back(b);
      end
    end
    $fclose(fd);
  endtask

  task automatic apply_reset();
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
    // one idle edge so the checker sees the post-reset state
    @(posedge clk);
  endtask

  task automatic drive_vectors();
    for (int i = 0; i < vec_fn.size(); i++) begin
      req_val <= 1'b1;
      req_fn  <= vec_fn[i];
      req_a   <= vec_a[i];
      req_b   <= vec_b[i];
      // hold the vector until the DUT takes it
      @(posedge clk);
      while (!req_rdy) begin
        @(posedge clk);
      end
    end
    req_val <= 1'b0;
  endtask

  initial begin : stimulus
    int fd;
    reset       = 1'b1;
    req_val     = 1'b0;
    req_fn      = fn_mul;
    req_a       = '0;
    req_b       = '0;
    cycle_limit = reset_cycles + 100;
    fd = $fopen("dv/imuldiv_input.dat", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file dv/imuldiv_input.dat");
      $display("Test failed");
      $finish;
    end else begin
      load_vectors(fd);
      cycle_limit = vec_fn.size() * cycles_per_vec + 100;
      apply_reset();
      drive_vectors();
      wait (done === 1'b1);
      // quiet stretch to catch a duplicated response
      repeat (40) @(posedge clk);
      $display("%0d vectors: %0d passed, %0d failed, %0d protocol errors",
               vec_fn.size(), pass_count, fail_count, error_count);
      if (fail_count == 0 && error_count == 0 && pass_count == vec_fn.size()) begin
        $display("Test passed");
      end else begin
        $display("Test failed");
      end
      $finish;
    end
  end

  // resp_rdy low for 0 to 7 cycles of each response
  initial begin : rdy_stall
    resp_rdy   = 1'b0;
    stall_left = 0;
    forever begin
      @(posedge clk);
      if (reset) begin
        resp_rdy  <= 1'b0;
        stall_left = 0;
      end else if (resp_val && resp_rdy) begin
        resp_rdy  <= 1'b0;
        stall_left = $random(seed) & 7;
      end else if (stall_left == 0) begin
        resp_rdy <= 1'b1;
      end else if (resp_val) begin
        if (stall_left == 1) resp_rdy <= 1'b1;
        stall_left = stall_left - 1;
      end
    end
  end

  initial begin : watchdog
    cycle_count = 0;
    forever begin
      @(posedge clk);
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit) begin
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Test failed");
        $finish;
      end
    end
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+design
design/imuldiv_msg_pkg.sv
design/imuldiv_ctrl_pkg.sv
design/int_mul_dpath.sv
design/int_mul_iterative.sv
design/int_div_iterative.sv
design/imuldiv_top.sv
dv/imuldiv_checker.sv
dv/tb_imuldiv.sv
